// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 4;
    localparam int OP_W   = 4;

    typedef logic [DATA_W-1:0] data_t;   // Bus byte
    typedef logic [ADDR_W-1:0] addr_t;   // PC and memory address
    typedef logic [OP_W-1:0]   opcode_t; // Upper nibble of an instruction

    // ==============================
    // Opcodes
    // ==============================
    localparam opcode_t OP_LDA = 4'h0;
    localparam opcode_t OP_ADD = 4'h1;
    localparam opcode_t OP_SUB = 4'h2;
    localparam opcode_t OP_STA = 4'h3;
    localparam opcode_t OP_LDI = 4'h4;
    localparam opcode_t OP_JMP = 4'h5;
    localparam opcode_t OP_JC  = 4'h6;
    localparam opcode_t OP_JZ  = 4'h7;
    localparam opcode_t OP_OUT = 4'hE;
    localparam opcode_t OP_HLT = 4'hF;

endpackage

`default_nettype wire

// ==== hdl/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    // Micro-step ring of five steps per instruction
    typedef enum logic [2:0] {
        T0 = 3'd0, // Fetch address
        T1 = 3'd1, // Fetch instruction
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4
    } step_e;

    // Sequencer run state
    typedef enum logic [1:0] {
        LOAD = 2'd0, // Program being written
        RUN  = 2'd1,
        HALT = 2'd2
    } run_e;

endpackage

`default_nettype wire

// ==== hdl/program_counter.sv ====
`default_nettype none

module program_counter (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          count,
    input  logic          load,
    input  isa_pkg::addr_t load_value,
    output isa_pkg::addr_t value
);

    isa_pkg::addr_t pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (load) begin
            pc_q <= load_value; // Jump target
        end else if (count) begin
            pc_q <= pc_q + 1'b1; // Wraps at 16
        end
    end

    assign value = pc_q;

endmodule

`default_nettype wire

// ==== hdl/control_sequencer.sv ====
`default_nettype none

module control_sequencer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load_mode,
    input  isa_pkg::opcode_t opcode,
    input  logic             carry,
    input  logic             zero,
    output logic             pc_count,
    output logic             pc_enable,
    output logic             pc_load,
    output logic             mar_load,
    output logic             ram_write,
    output logic             ram_enable,
    output logic             ir_load,
    output logic             ir_enable,
    output logic             a_load,
    output logic             a_enable,
    output logic             alu_sub,
    output logic             alu_enable,
    output logic             b_load,
    output logic             out_load,
    output logic             halted
);

    ctrl_pkg::run_e  state_q;
    ctrl_pkg::step_e step_q;
    ctrl_pkg::step_e step_next;
    logic            run_active;
    logic            is_arith;
    logic            take_jump;

    // ==============================
    // State and step ring
    // ==============================
    always_comb begin
        case (step_q)
            ctrl_pkg::T0: step_next = ctrl_pkg::T1;
            ctrl_pkg::T1: step_next = ctrl_pkg::T2;
            ctrl_pkg::T2: step_next = ctrl_pkg::T3;
            ctrl_pkg::T3: step_next = ctrl_pkg::T4;
            default:      step_next = ctrl_pkg::T0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ctrl_pkg::RUN;
            step_q  <= ctrl_pkg::T0;
        end else if (load_mode) begin
            state_q <= ctrl_pkg::LOAD;
            step_q  <= ctrl_pkg::T0;
        end else begin
            case (state_q)
                ctrl_pkg::LOAD: begin
                    state_q <= ctrl_pkg::RUN; // Load mode released
                    step_q  <= ctrl_pkg::T0;
                end
                ctrl_pkg::RUN: begin
                    if (step_q == ctrl_pkg::T2 && opcode == isa_pkg::OP_HLT) begin
                        state_q <= ctrl_pkg::HALT;
                        step_q  <= ctrl_pkg::T0;
                    end else begin
                        step_q <= step_next;
                    end
                end
                ctrl_pkg::HALT: step_q <= ctrl_pkg::T0; // Wait for reset or load mode
                default:        state_q <= ctrl_pkg::RUN;
            endcase
        end
    end

    assign halted     = (state_q == ctrl_pkg::HALT);
    assign run_active = (state_q == ctrl_pkg::RUN) && !load_mode;
    assign is_arith   = (opcode == isa_pkg::OP_ADD) || (opcode == isa_pkg::OP_SUB);
    assign take_jump  = (opcode == isa_pkg::OP_JMP) ||
                        (opcode == isa_pkg::OP_JC && carry) ||
                        (opcode == isa_pkg::OP_JZ && zero);

    // ==============================
    // Strobe decode
    // ==============================
    always_comb begin
        pc_count   = 1'b0;
        pc_enable  = 1'b0;
        pc_load    = 1'b0;
        mar_load   = 1'b0;
        ram_write  = 1'b0;
        ram_enable = 1'b0;
        ir_load    = 1'b0;
        ir_enable  = 1'b0;
        a_load     = 1'b0;
        a_enable   = 1'b0;
        alu_sub    = 1'b0;
        alu_enable = 1'b0;
        b_load     = 1'b0;
        out_load   = 1'b0;
        if (run_active) begin
            case (step_q)
                ctrl_pkg::T0: begin
                    pc_enable = 1'b1;
                    mar_load  = 1'b1;
                end
                ctrl_pkg::T1: begin
                    ram_enable = 1'b1;
                    ir_load    = 1'b1;
                    pc_count   = 1'b1;
                end
                ctrl_pkg::T2: begin
                    if (opcode == isa_pkg::OP_LDA || opcode == isa_pkg::OP_STA || is_arith) begin
                        ir_enable = 1'b1; // Operand address to MAR
                        mar_load  = 1'b1;
                    end else if (opcode == isa_pkg::OP_LDI) begin
                        ir_enable = 1'b1;
                        a_load    = 1'b1;
                    end else if (take_jump) begin
                        ir_enable = 1'b1;
                        pc_load   = 1'b1;
                    end else if (opcode == isa_pkg::OP_OUT) begin
                        a_enable = 1'b1;
                        out_load = 1'b1;
                    end
                end
                ctrl_pkg::T3: begin
                    if (opcode == isa_pkg::OP_LDA) begin
                        ram_enable = 1'b1;
                        a_load     = 1'b1;
                    end else if (is_arith) begin
                        ram_enable = 1'b1;
                        b_load     = 1'b1;
                    end else if (opcode == isa_pkg::OP_STA) begin
                        a_enable  = 1'b1;
                        ram_write = 1'b1;
                    end
                end
                ctrl_pkg::T4: begin
                    if (is_arith) begin
                        alu_enable = 1'b1;
                        a_load     = 1'b1;
                        alu_sub    = (opcode == isa_pkg::OP_SUB);
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alu_unit.sv ====
`default_nettype none

module alu_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  isa_pkg::data_t bus,
    input  logic           a_load,
    input  logic           b_load,
    input  logic           sub,
    input  logic           flag_load,
    output isa_pkg::data_t acc,
    output isa_pkg::data_t result,
    output logic           carry,
    output logic           zero
);

    isa_pkg::data_t a_q;
    isa_pkg::data_t b_q;
    isa_pkg::data_t b_operand;
    logic           carry_out;
    logic           carry_q;
    logic           zero_q;

    always_ff @(posedge clk) begin
        if (a_load) begin
            a_q <= bus;
        end
        if (b_load) begin
            b_q <= bus;
        end
    end

    // Two's complement subtract where carry out means no borrow
    assign b_operand = sub ? ~b_q : b_q;
    assign {carry_out, result} = {1'b0, a_q} + {1'b0, b_operand} + {8'h00, sub};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            carry_q <= 1'b0;
            zero_q  <= 1'b0;
        end else if (flag_load) begin
            carry_q <= carry_out;
            zero_q  <= (result == '0);
        end
    end

    assign acc   = a_q;
    assign carry = carry_q;
    assign zero  = zero_q;

endmodule

`default_nettype wire

// ==== hdl/memory_unit.sv ====
`default_nettype none

module memory_unit #(
    parameter int RAM_BYTES = 16 // Power of two and at least 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  isa_pkg::data_t   bus,
    input  logic             mar_load,
    input  logic             ram_write,
    input  logic             ir_load,
    input  logic             prog_write,
    input  isa_pkg::addr_t   prog_addr,
    input  isa_pkg::data_t   prog_data,
    output isa_pkg::data_t   ram_data,
    output isa_pkg::opcode_t opcode,
    output isa_pkg::addr_t   operand
);

    localparam int IDX_W = $clog2(RAM_BYTES);

    isa_pkg::data_t mem [RAM_BYTES];
    isa_pkg::addr_t mar_q;
    isa_pkg::data_t ir_q;
    logic [IDX_W-1:0] run_idx;
    logic [IDX_W-1:0] prog_idx;

    // Upper address bits drop out, so small RAMs wrap
    assign run_idx  = mar_q[IDX_W-1:0];
    assign prog_idx = prog_addr[IDX_W-1:0];

    // ==============================
    // Address register
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar_q <= '0;
        end else if (mar_load) begin
            mar_q <= bus[3:0];
        end
    end

    // ==============================
    // RAM array
    // ==============================
    always_ff @(posedge clk) begin
        if (prog_write) begin
            mem[prog_idx] <= prog_data; // Load-mode port
        end else if (ram_write) begin
            mem[run_idx] <= bus;
        end
    end

    assign ram_data = mem[run_idx];

    // ==============================
    // Instruction register
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_q <= '0;
        end else if (ir_load) begin
            ir_q <= bus;
        end
    end

    assign opcode  = ir_q[7:4];
    assign operand = ir_q[3:0];

endmodule

`default_nettype wire

// ==== hdl/sap_cpu_top.sv ====
`default_nettype none

module sap_cpu_top #(
    parameter int RAM_BYTES = 16
) (
    input  logic [7:0] ui_in,
    output logic [7:0] uo_out,
    input  logic [7:0] uio_in,
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    input  logic       ena,
    input  logic       clk,
    input  logic       rst_n
);

    isa_pkg::data_t   bus;
    isa_pkg::addr_t   pc_value;
    isa_pkg::data_t   ram_data;
    isa_pkg::opcode_t opcode;
    isa_pkg::addr_t   operand;
    isa_pkg::data_t   acc;
    isa_pkg::data_t   alu_result;
    isa_pkg::data_t   out_q;
    logic             out_strobe_q;
    logic             carry;
    logic             zero;
    logic             load_mode;
    logic             prog_write;
    logic             pc_rst_n;

    logic pc_count, pc_enable, pc_load;
    logic mar_load, ram_write, ram_enable;
    logic ir_load, ir_enable;
    logic a_load, a_enable, alu_sub, alu_enable, b_load;
    logic out_load, halted;

    // ==============================
    // Load-mode pins
    // ==============================
    assign load_mode  = ui_in[7];
    assign prog_write = ui_in[7] & ui_in[4];
    assign pc_rst_n   = rst_n & ~load_mode; // Run restarts at address 0

    program_counter u_pc (
        .clk        (clk),
        .rst_n      (pc_rst_n),
        .count      (pc_count),
        .load       (pc_load),
        .load_value (bus[3:0]),
        .value      (pc_value)
    );

    control_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_mode  (load_mode),
        .opcode     (opcode),
        .carry      (carry),
        .zero       (zero),
        .pc_count   (pc_count),
        .pc_enable  (pc_enable),
        .pc_load    (pc_load),
        .mar_load   (mar_load),
        .ram_write  (ram_write),
        .ram_enable (ram_enable),
        .ir_load    (ir_load),
        .ir_enable  (ir_enable),
        .a_load     (a_load),
        .a_enable   (a_enable),
        .alu_sub    (alu_sub),
        .alu_enable (alu_enable),
        .b_load     (b_load),
        .out_load   (out_load),
        .halted     (halted)
    );

    alu_unit u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .a_load    (a_load),
        .b_load    (b_load),
        .sub       (alu_sub),
        .flag_load (alu_enable), // Flags only move on the arithmetic step
        .acc       (acc),
        .result    (alu_result),
        .carry     (carry),
        .zero      (zero)
    );

    memory_unit #(
        .RAM_BYTES (RAM_BYTES)
    ) u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus),
        .mar_load   (mar_load),
        .ram_write  (ram_write),
        .ir_load    (ir_load),
        .prog_write (prog_write),
        .prog_addr  (ui_in[3:0]),
        .prog_data  (uio_in),
        .ram_data   (ram_data),
        .opcode     (opcode),
        .operand    (operand)
    );

    // Bus source with one enable per step
    always_comb begin
        if (pc_enable) begin
            bus = {4'h0, pc_value};
        end else if (ram_enable) begin
            bus = ram_data;
        end else if (ir_enable) begin
            bus = {4'h0, operand};
        end else if (a_enable) begin
            bus = acc;
        end else if (alu_enable) begin
            bus = alu_result;
        end else begin
            bus = '0;
        end
    end

    // ==============================
    // Output register and status
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q        <= '0;
            out_strobe_q <= 1'b0;
        end else begin
            out_strobe_q <= out_load; // Marks the new uo_out value
            if (out_load) begin
                out_q <= bus;
            end
        end
    end

    assign uo_out  = out_q;
    assign uio_out = {6'b000000, out_strobe_q & ~load_mode, halted};
    assign uio_oe  = 8'h03;

endmodule

`default_nettype wire

// ==== testbench/sap_cpu_asserts.sv ====
`default_nettype none

module sap_cpu_asserts (
    input logic clk,
    input logic rst_n,
    input logic load_mode,
    input logic strobe,
    input logic halted
);

    timeunit 1ns;
    timeprecision 1ps;

    // ==============================
    // Strobe and halt rules
    // ==============================
    property strobe_one_cycle;
        @(posedge clk) disable iff (!rst_n) strobe |=> !strobe;
    endproperty

    // Only reset or load mode may drop the halt
    property halt_sticky;
        @(posedge clk) disable iff (!rst_n) (halted && !load_mode) |=> halted;
    endproperty

    // No OUT step may run while the load pin is up
    property no_strobe_in_load;
        @(posedge clk) disable iff (!rst_n) load_mode |=> !strobe;
    endproperty

    property no_strobe_when_halted;
        @(posedge clk) disable iff (!rst_n) halted |-> !strobe;
    endproperty

    assert property (strobe_one_cycle) else $error("Output strobe lasted two cycles");
    assert property (halt_sticky) else $error("Halted fell without reset or load mode");
    assert property (no_strobe_in_load) else $error("Output strobe followed a load-mode cycle");
    assert property (no_strobe_when_halted) else $error("Output strobe fired while halted");

endmodule

bind sap_cpu_top sap_cpu_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_mode (ui_in[7]),
    .strobe    (uio_out[1]),
    .halted    (uio_out[0])
);

`default_nettype wire

// ==== testbench/tb_sap_cpu.sv ====
`default_nettype none

module tb_sap_cpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 100;
    localparam int          INSTR_BUDGET = 64;  // Instructions allowed per program
    localparam int          REC_WORDS    = 26;  // Name, 16 bytes, count, 8 outputs
    localparam int          RAND_TESTS   = 3;
    localparam logic [31:0] LFSR_SEED    = 32'h4b4ce8e4;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    logic [7:0]  tdata [0:255];
    logic [7:0]  prog_buf [0:15];
    logic [7:0]  exp_buf [0:7];
    logic [7:0]  seen [$];
    logic        collecting;
    logic        data_ready;
    logic [31:0] lfsr_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          num_file_tests;

    sap_cpu_top #(
        .RAM_BYTES (16)
    ) u_dut (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Every value on uo_out while the strobe is up
    always @(negedge clk) begin
        if (collecting && uio_out[1] === 1'b1) begin
            seen.push_back(uo_out);
        end
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic string test_name(input logic [7:0] idx);
        case (idx)
            8'd0:    return "arith_wrap";
            8'd1:    return "countdown_jz";
            8'd2:    return "carry_jc";
            8'd3:    return "store_reload";
            8'd4:    return "zero_flags";
            default: return "unnamed";
        endcase
    endfunction

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random_byte(output logic [7:0] b);
        int k;
        b = 8'h00;
        for (k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]}; // One step per bit
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %0h, actual %0h", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst_n  <= 1'b0;
        ui_in  <= 8'h80; // Load mode held so nothing runs
        uio_in <= 8'h00;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            ui_in  <= {1'b1, 2'b00, 1'b1, i[3:0]};
            uio_in <= prog_buf[i];
        end
        @(posedge clk);
        ui_in <= 8'h80;
        @(posedge clk);
        ui_in <= 8'h00; // Run starts at address 0
    endtask

    task automatic run_program(input string name, input int exp_count);
        int cycles;
        int err_before;
        int late;
        int dropped;
        int i;
        err_before = errors;
        cycles     = 0;
        late       = 0;
        dropped    = 0;
        seen.delete();
        collecting = 1'b1;
        load_program();
        while (uio_out[0] !== 1'b1 && cycles < 5 * INSTR_BUDGET) begin
            @(negedge clk);
            cycles++;
        end
        collecting = 1'b0;
        if (uio_out[0] !== 1'b1) begin
            $display("%s: CPU did not halt within %0d instructions", name, INSTR_BUDGET);
            errors++;
        end else begin
            repeat (20) begin
                @(negedge clk);
                if (uio_out[1] !== 1'b0) late++;
                if (uio_out[0] !== 1'b1) dropped++;
            end
            check_value(name, "strobes after halt", 0, late);
            check_value(name, "cycles with halt dropped", 0, dropped);
            @(posedge clk);
            ui_in <= 8'h80; // Load mode releases the halt
            @(posedge clk);
            @(negedge clk);
            check_value(name, "halted in load mode", 0, uio_out[0]);
        end
        check_value(name, "output count", exp_count, seen.size());
        for (i = 0; i < seen.size() && i < exp_count; i++) begin
            check_value(name, $sformatf("output %0d", i), exp_buf[i], seen[i]);
        end
        tests_run++;
        if (errors == err_before) begin
            $display("%-14s pass", name);
        end else begin
            tests_failed++;
            $display("%-14s fail", name);
        end
    endtask

    // ==============================
    // Watchdog
    // ==============================
    initial begin
        longint limit_ns;
        wait (data_ready);
        limit_ns = (longint'(num_file_tests) + RAND_TESTS + 1) *
                   (5 * INSTR_BUDGET + 64) * CLK_PERIOD + 100 * CLK_PERIOD;
        #(limit_ns);
        $display("Watchdog: the run did not end within %0d ns and was stopped", limit_ns);
        $display("Finished with errors");
        $finish;
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int         t;
        int         i;
        int         base;
        int         err_before;
        logic [7:0] x;
        logic [7:0] y;
        rst_n        = 1'b0;
        ena          = 1'b1;
        ui_in        = 8'h80;
        uio_in       = 8'h00;
        collecting   = 1'b0;
        data_ready   = 1'b0;
        lfsr_state   = LFSR_SEED;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        $readmemh("testbench/sap_cpu_testdata.txt", tdata);
        if ($isunknown(tdata[0])) begin
            $display("Test data file could not be read");
            errors++;
            num_file_tests = 0;
        end else begin
            num_file_tests = tdata[0];
        end
        data_ready = 1'b1;

        reset_dut();
        @(negedge clk);
        err_before = errors;
        check_value("reset_state", "uo_out", 0, uo_out);
        check_value("reset_state", "halted", 0, uio_out[0]);
        check_value("reset_state", "strobe", 0, uio_out[1]);
        check_value("reset_state", "uio_out spare bits", 0, uio_out[7:2]);
        check_value("reset_state", "uio_oe", 8'h03, uio_oe);
        tests_run++;
        if (errors == err_before) begin
            $display("%-14s pass", "reset_state");
        end else begin
            tests_failed++;
            $display("%-14s fail", "reset_state");
        end

        for (t = 0; t < num_file_tests; t++) begin
            base = 1 + t * REC_WORDS;
            for (i = 0; i < 16; i++) prog_buf[i] = tdata[base + 1 + i];
            for (i = 0; i < 8; i++) exp_buf[i] = tdata[base + 18 + i];
            reset_dut();
            run_program(test_name(tdata[base]), tdata[base + 17]);
        end

        // Add then subtract on two LFSR bytes
        for (t = 0; t < RAND_TESTS; t++) begin
            take_random_byte(x);
            take_random_byte(y);
            for (i = 0; i < 16; i++) prog_buf[i] = 8'h00;
            prog_buf[0]  = 8'h0E; // LDA 14
            prog_buf[1]  = 8'h1F; // ADD 15
            prog_buf[2]  = 8'hE0;
            prog_buf[3]  = 8'h2F; // SUB 15
            prog_buf[4]  = 8'hE0;
            prog_buf[5]  = 8'h2F;
            prog_buf[6]  = 8'hE0;
            prog_buf[7]  = 8'hF0;
            prog_buf[14] = x;
            prog_buf[15] = y;
            exp_buf[0]   = x + y;
            exp_buf[1]   = x;
            exp_buf[2]   = x - y;
            reset_dut();
            run_program($sformatf("random_addsub%0d", t), 3);
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/sap_cpu_testdata.txt ====
// Record: name index, 16 program bytes (address 0 to 15),
// expected output count, 8 expected output slots (unused ones 00)
// The first word is the number of records
05

// arith_wrap: C8+5A wraps to 22, then 22-30 wraps to F2
00
0E 1F E0 2D E0 F0 00 00 00 00 00 00 00 30 C8 5A
02 22 F2 00 00 00 00 00 00

// countdown_jz: 3 down to 0 by SUB 1, JZ leaves the loop
01
0F E0 2E E0 76 52 F0 00 00 00 00 00 00 00 01 03
04 03 02 01 00 00 00 00 00

// carry_jc: ADD carry taken, SUB with borrow not taken
02
0F 1E 65 E0 F0 E0 2D 6A E0 F0 E0 F0 00 20 20 F0
02 10 F0 00 00 00 00 00 00

// store_reload: STA then LDA of address 14, then LDI 12
03
49 1F 3E 40 0E E0 4C E0 F0 00 00 00 00 00 00 37
02 40 0C 00 00 00 00 00 00

// zero_flags: SUB to zero sets Z and C, ADD clears both
04
0F 2F 74 F0 E0 67 F0 1E 7B E0 F0 E0 F0 00 7F 55
02 00 7F 00 00 00 00 00 00

// ==== project.f ====
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/program_counter.sv
hdl/control_sequencer.sv
hdl/alu_unit.sv
hdl/memory_unit.sv
hdl/sap_cpu_top.sv
testbench/sap_cpu_asserts.sv
testbench/tb_sap_cpu.sv

// ==== Bender.yml ====
package:
  name: sap_cpu

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - hdl/isa_pkg.sv
      - hdl/ctrl_pkg.sv
      - hdl/program_counter.sv
      - hdl/control_sequencer.sv
      - hdl/alu_unit.sv
      - hdl/memory_unit.sv
      - hdl/sap_cpu_top.sv

  # Simulation only
  - target: test
    files:
      - testbench/sap_cpu_asserts.sv
      - testbench/tb_sap_cpu.sv
